/* src/conv_pkg.sv */
package conv_pkg;

    localparam int ADDR_W       = 12;
    localparam int DATA_W       = 32;
    localparam int MEM_DEPTH    = 256;
    localparam int MEM_AW       = 8;
    localparam int MEM_BASE_BIT = 10;     // window 0x400..0x7fc

    localparam int KERNEL     = 3;
    localparam int FM_DIM_MIN = 3;
    localparam int FM_DIM_MAX = 16;

    // register word indices
    localparam logic [5:0] REG_CTRL    = 6'd0;
    localparam logic [5:0] REG_STATUS  = 6'd1;
    localparam logic [5:0] REG_FM_DIM  = 6'd2;
    localparam logic [5:0] REG_IFM_OFF = 6'd3;
    localparam logic [5:0] REG_WT_OFF  = 6'd4;
    localparam logic [5:0] REG_OFM_OFF = 6'd5;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef union packed {
        struct packed {
            logic       top;
            logic       region;
            logic [1:0] rsvd;
            logic [5:0] idx;
            logic [1:0] byte_off;
        } reg_view;
        struct packed {
            logic       top;
            logic       region;
            logic [7:0] idx;
            logic [1:0] byte_off;
        } mem_view;
    } host_addr_t;

endpackage

/* src/conv_ifs.sv */
`timescale 1ns/1ps

interface conv_reg_if;
    import conv_pkg::*;
    logic              req;
    logic              we;
    host_addr_t        addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              ack;
    logic              err;
    modport master (output req, we, addr, wdata, input rdata, ack, err);
    modport slave  (input req, we, addr, wdata, output rdata, ack, err);
endinterface

interface conv_mem_if;
    import conv_pkg::*;
    logic              en;
    logic              we;
    logic [MEM_AW-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;   // one cycle after a read
    modport master (output en, we, addr, wdata, input rdata);
    modport slave  (input en, we, addr, wdata, output rdata);
endinterface

interface conv_cmd_if;
    import conv_pkg::*;
    logic              start;
    logic              soft_rst;
    logic [DATA_W-1:0] fm_dim;
    logic [DATA_W-1:0] ifm_off;
    logic [DATA_W-1:0] wt_off;
    logic [DATA_W-1:0] ofm_off;
    logic              idle;
    logic              done;
    modport controller (output start, soft_rst, fm_dim, ifm_off, wt_off, ofm_off,
                        input idle, done);
    modport engine     (input start, soft_rst, fm_dim, ifm_off, wt_off, ofm_off,
                        output idle, done);
endinterface

/* src/conv_axil_slave.sv */
`timescale 1ns/1ps

module conv_axil_slave (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic [conv_pkg::ADDR_W-1:0]  s_awaddr_i,
    input  logic                         s_awvalid_i,
    output logic                         s_awready_o,
    input  logic [conv_pkg::DATA_W-1:0]  s_wdata_i,
    input  logic                         s_wvalid_i,
    output logic                         s_wready_o,
    output logic [1:0]                   s_bresp_o,
    output logic                         s_bvalid_o,
    input  logic                         s_bready_i,
    input  logic [conv_pkg::ADDR_W-1:0]  s_araddr_i,
    input  logic                         s_arvalid_i,
    output logic                         s_arready_o,
    output logic [conv_pkg::DATA_W-1:0]  s_rdata_o,
    output logic [1:0]                   s_rresp_o,
    output logic                         s_rvalid_o,
    input  logic                         s_rready_i,
    conv_reg_if.master                   reg_bus
);
    import conv_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_WAIT, S_RESP} state_e;

    state_e            state_q;
    logic              is_wr_q;
    logic [1:0]        resp_q;
    logic [DATA_W-1:0] rdata_q;
    logic              wr_go;
    logic              rd_go;

    assign wr_go = (state_q == S_IDLE) && s_awvalid_i && s_wvalid_i;
    assign rd_go = (state_q == S_IDLE) && s_arvalid_i && !wr_go;   // writes win

    assign s_awready_o = wr_go;
    assign s_wready_o  = wr_go;
    assign s_arready_o = rd_go;

    // single-cycle request in the handshake cycle
    assign reg_bus.req   = wr_go || rd_go;
    assign reg_bus.we    = wr_go;
    assign reg_bus.addr  = wr_go ? host_addr_t'(s_awaddr_i) : host_addr_t'(s_araddr_i);
    assign reg_bus.wdata = s_wdata_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
            is_wr_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: if (reg_bus.req) begin
                    state_q <= S_WAIT;
                    is_wr_q <= wr_go;
                end
                S_WAIT: if (reg_bus.ack) state_q <= S_RESP;
                S_RESP: if (is_wr_q ? s_bready_i : s_rready_i) state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == S_WAIT && reg_bus.ack) begin
            resp_q  <= reg_bus.err ? RESP_SLVERR : RESP_OKAY;
            rdata_q <= reg_bus.rdata;
        end
    end

    assign s_bvalid_o = (state_q == S_RESP) && is_wr_q;
    assign s_rvalid_o = (state_q == S_RESP) && !is_wr_q;
    assign s_bresp_o  = resp_q;
    assign s_rresp_o  = resp_q;
    assign s_rdata_o  = rdata_q;

    // response must hold steady under back-pressure
    a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));
    a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o));

endmodule

/* src/conv_controller.sv */
`timescale 1ns/1ps

module conv_controller (
    input  logic            clk_i,
    input  logic            arst_n_i,
    conv_reg_if.slave       reg_bus,
    conv_mem_if.master      host_mem,
    conv_cmd_if.controller  cmd,
    output logic            active_o
);
    import conv_pkg::*;

    logic [DATA_W-1:0] fm_dim_q, ifm_off_q, wt_off_q, ofm_off_q;
    logic              active_q, done_q, idle_q;
    logic              start_q, soft_q;
    logic              ack_q, err_q, mem_rd_q;
    logic [DATA_W-1:0] rdata_q;
    logic [DATA_W-1:0] reg_rdata;
    logic              is_reg, is_mem, ctrl_wr, start_req, start_ok, soft_req, dim_ok, bad;
    logic [5:0]        ridx;

    assign ridx   = reg_bus.addr.reg_view.idx;
    assign is_mem = reg_bus.addr[MEM_BASE_BIT] && !reg_bus.addr.mem_view.top;
    assign is_reg = !reg_bus.addr.reg_view.top && !reg_bus.addr.reg_view.region &&
                    reg_bus.addr.reg_view.rsvd == 2'b00 && ridx <= REG_OFM_OFF;

    assign dim_ok    = fm_dim_q >= FM_DIM_MIN && fm_dim_q <= FM_DIM_MAX;
    assign ctrl_wr   = reg_bus.req && reg_bus.we && is_reg && ridx == REG_CTRL;
    assign soft_req  = ctrl_wr && reg_bus.wdata[1];
    assign start_req = ctrl_wr && reg_bus.wdata[0] && !reg_bus.wdata[1];
    assign start_ok  = start_req && !active_q && dim_ok;
    assign bad       = (is_mem && active_q) || (!is_mem && !is_reg) || (start_req && !start_ok);

    // memory window only while the engine is parked
    assign host_mem.en    = reg_bus.req && is_mem && !active_q;
    assign host_mem.we    = reg_bus.we;
    assign host_mem.addr  = reg_bus.addr.mem_view.idx;
    assign host_mem.wdata = reg_bus.wdata;

    always_comb begin
        reg_rdata = '0;
        if (is_reg && !reg_bus.we) begin
            case (ridx)
                REG_STATUS:  reg_rdata = {29'b0, active_q, idle_q, done_q};
                REG_FM_DIM:  reg_rdata = fm_dim_q;
                REG_IFM_OFF: reg_rdata = ifm_off_q;
                REG_WT_OFF:  reg_rdata = wt_off_q;
                REG_OFM_OFF: reg_rdata = ofm_off_q;
                default:     reg_rdata = '0;    // ctrl reads as zero
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q    <= 1'b0;
            err_q    <= 1'b0;
            mem_rd_q <= 1'b0;
            rdata_q  <= '0;
        end else begin
            ack_q    <= reg_bus.req;
            mem_rd_q <= host_mem.en && !host_mem.we;
            if (reg_bus.req) begin
                err_q   <= bad;
                rdata_q <= reg_rdata;
            end
        end
    end

    assign reg_bus.ack   = ack_q;
    assign reg_bus.err   = err_q;
    assign reg_bus.rdata = mem_rd_q ? host_mem.rdata : rdata_q;

    // scalar registers survive soft reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fm_dim_q  <= '0;
            ifm_off_q <= '0;
            wt_off_q  <= '0;
            ofm_off_q <= '0;
        end else if (reg_bus.req && reg_bus.we && is_reg) begin
            case (ridx)
                REG_FM_DIM:  fm_dim_q  <= reg_bus.wdata;
                REG_IFM_OFF: ifm_off_q <= reg_bus.wdata;
                REG_WT_OFF:  wt_off_q  <= reg_bus.wdata;
                REG_OFM_OFF: ofm_off_q <= reg_bus.wdata;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            start_q  <= 1'b0;
            soft_q   <= 1'b0;
            active_q <= 1'b0;
            done_q   <= 1'b0;
            idle_q   <= 1'b1;
        end else begin
            start_q <= start_ok;
            soft_q  <= soft_req;
            idle_q  <= cmd.idle;
            if (soft_q) begin
                active_q <= 1'b0;
                done_q   <= 1'b0;
            end else begin
                if (cmd.start || cmd.done) active_q <= ~active_q;   // toggle on start and done
                if (cmd.start) done_q <= 1'b0;
                else if (cmd.done) done_q <= 1'b1;
            end
        end
    end

    assign cmd.start    = start_q;
    assign cmd.soft_rst = soft_q;
    assign cmd.fm_dim   = fm_dim_q;
    assign cmd.ifm_off  = ifm_off_q;
    assign cmd.wt_off   = wt_off_q;
    assign cmd.ofm_off  = ofm_off_q;
    assign active_o     = active_q;

    a_no_start_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        cmd.start |-> !active_q && cmd.idle);

endmodule

/* src/conv_engine.sv */
`timescale 1ns/1ps

module conv_engine (
    input  logic        clk_i,
    input  logic        arst_n_i,
    conv_cmd_if.engine  cmd,
    conv_mem_if.master  mem
);
    import conv_pkg::*;

    typedef enum logic [2:0] {E_IDLE, E_WLOAD, E_RUN, E_WRITE, E_DONE} eng_state_e;

    eng_state_e               state_q;
    logic [3:0]               iss_q;      // read issue count
    logic                     rvld_q;
    logic [3:0]               rtap_q;
    logic [1:0]               kx_q, ky_q;
    logic [3:0]               ox_q, oy_q;
    logic [MEM_AW-1:0]        out_idx_q;
    logic signed [DATA_W-1:0] w_q [KERNEL*KERNEL];
    logic signed [DATA_W-1:0] acc_q;
    logic signed [DATA_W-1:0] prod;
    logic [DATA_W-1:0]        addr_full;
    logic [4:0]               dim, last_pos;
    logic                     issuing, last_tap, last_out;

    assign dim      = cmd.fm_dim[4:0];
    assign last_pos = dim - 5'd3;
    assign issuing  = (state_q == E_WLOAD || state_q == E_RUN) && iss_q < 4'd9;
    assign last_tap = rvld_q && rtap_q == 4'd8;
    assign last_out = {1'b0, ox_q} == last_pos && {1'b0, oy_q} == last_pos;
    assign prod     = w_q[rtap_q] * $signed(mem.rdata);   // low 32 bits kept

    always_comb begin
        case (state_q)
            E_WLOAD: addr_full = cmd.wt_off + DATA_W'(iss_q);
            E_WRITE: addr_full = cmd.ofm_off + DATA_W'(out_idx_q);
            default: addr_full = cmd.ifm_off + DATA_W'(oy_q + ky_q) * DATA_W'(dim) +
                                 DATA_W'(ox_q) + DATA_W'(kx_q);
        endcase
    end

    assign mem.en    = issuing || state_q == E_WRITE;
    assign mem.we    = state_q == E_WRITE;
    assign mem.addr  = addr_full[MEM_AW-1:0];
    assign mem.wdata = acc_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= E_IDLE;
            iss_q     <= '0;
            rvld_q    <= 1'b0;
            rtap_q    <= '0;
            kx_q      <= '0;
            ky_q      <= '0;
            ox_q      <= '0;
            oy_q      <= '0;
            out_idx_q <= '0;
        end else if (cmd.soft_rst) begin
            state_q <= E_IDLE;
            rvld_q  <= 1'b0;
        end else begin
            rvld_q <= issuing;
            rtap_q <= iss_q;
            if (issuing) begin
                iss_q <= iss_q + 4'd1;
                if (kx_q == 2'd2) begin
                    kx_q <= '0;
                    ky_q <= ky_q + 2'd1;
                end else begin
                    kx_q <= kx_q + 2'd1;
                end
            end
            case (state_q)
                E_IDLE: if (cmd.start) begin
                    state_q   <= E_WLOAD;
                    iss_q     <= '0;
                    ox_q      <= '0;
                    oy_q      <= '0;
                    out_idx_q <= '0;
                end
                E_WLOAD, E_RUN: if (last_tap) begin
                    state_q <= (state_q == E_WLOAD) ? E_RUN : E_WRITE;
                    iss_q   <= '0;
                    kx_q    <= '0;
                    ky_q    <= '0;
                end
                E_WRITE: begin
                    out_idx_q <= out_idx_q + 1'b1;
                    state_q   <= last_out ? E_DONE : E_RUN;
                    if ({1'b0, ox_q} == last_pos) begin
                        ox_q <= '0;
                        oy_q <= oy_q + 4'd1;
                    end else begin
                        ox_q <= ox_q + 4'd1;
                    end
                end
                default: state_q <= E_IDLE;   // done lasts one cycle
            endcase
        end
    end

    // weight cache and accumulator
    always_ff @(posedge clk_i) begin
        if (rvld_q && state_q == E_WLOAD) w_q[rtap_q] <= $signed(mem.rdata);
        if (rvld_q && state_q == E_RUN) acc_q <= (rtap_q == 4'd0 ? '0 : acc_q) + prod;
    end

    assign cmd.idle = state_q == E_IDLE;
    assign cmd.done = state_q == E_DONE;

    // offsets come from host registers, so overflow past the array is a setup error
    a_addr_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        mem.en |-> addr_full < MEM_DEPTH);

endmodule

/* src/conv_scratch_mem.sv */
`timescale 1ns/1ps

module conv_scratch_mem (
    input  logic       clk_i,
    conv_mem_if.slave  host,
    conv_mem_if.slave  eng,
    input  logic       active_i
);
    import conv_pkg::*;

    logic [DATA_W-1:0] mem_q [MEM_DEPTH];
    logic [DATA_W-1:0] rdata_q;
    logic              en;
    logic              we;
    logic [MEM_AW-1:0] addr;
    logic [DATA_W-1:0] wdata;

    // engine owns the port during a run
    assign en    = active_i ? eng.en    : host.en;
    assign we    = active_i ? eng.we    : host.we;
    assign addr  = active_i ? eng.addr  : host.addr;
    assign wdata = active_i ? eng.wdata : host.wdata;

    always_ff @(posedge clk_i) begin
        if (en) begin
            if (we) mem_q[addr] <= wdata;
            else rdata_q <= mem_q[addr];
        end
    end

    assign host.rdata = rdata_q;
    assign eng.rdata  = rdata_q;

endmodule

/* src/conv_accel_top.sv */
`timescale 1ns/1ps

module conv_accel_top (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic [conv_pkg::ADDR_W-1:0]  s_awaddr_i,
    input  logic                         s_awvalid_i,
    output logic                         s_awready_o,
    input  logic [conv_pkg::DATA_W-1:0]  s_wdata_i,
    input  logic                         s_wvalid_i,
    output logic                         s_wready_o,
    output logic [1:0]                   s_bresp_o,
    output logic                         s_bvalid_o,
    input  logic                         s_bready_i,
    input  logic [conv_pkg::ADDR_W-1:0]  s_araddr_i,
    input  logic                         s_arvalid_i,
    output logic                         s_arready_o,
    output logic [conv_pkg::DATA_W-1:0]  s_rdata_o,
    output logic [1:0]                   s_rresp_o,
    output logic                         s_rvalid_o,
    input  logic                         s_rready_i
);

    conv_reg_if reg_bus ();
    conv_mem_if host_mem ();
    conv_mem_if eng_mem ();
    conv_cmd_if cmd ();

    logic active;

    conv_axil_slave i_axil (
        .clk_i, .arst_n_i,
        .s_awaddr_i, .s_awvalid_i, .s_awready_o,
        .s_wdata_i, .s_wvalid_i, .s_wready_o,
        .s_bresp_o, .s_bvalid_o, .s_bready_i,
        .s_araddr_i, .s_arvalid_i, .s_arready_o,
        .s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
        .reg_bus (reg_bus.master)
    );

    conv_controller i_ctrl (
        .clk_i, .arst_n_i,
        .reg_bus  (reg_bus.slave),
        .host_mem (host_mem.master),
        .cmd      (cmd.controller),
        .active_o (active)
    );

    conv_engine i_engine (
        .clk_i, .arst_n_i,
        .cmd (cmd.engine),
        .mem (eng_mem.master)
    );

    conv_scratch_mem i_mem (
        .clk_i,
        .host     (host_mem.slave),
        .eng      (eng_mem.slave),
        .active_i (active)
    );

endmodule

/* bench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;      // 10 ns period
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end
endmodule

/* bench/tb_conv_accel.sv */
`timescale 1ns/1ps

module tb_conv_accel;
    import conv_pkg::*;

    localparam int IFM_OFF = 0;
    localparam int WT_OFF  = 100;
    localparam int OFM_OFF = 120;
    // one d=5 run, four d=8 runs with the aborted one, ~650 accesses of up to 10 cycles
    localparam int CONV_CYC = 9 * 11 + 4 * 36 * 11 + 5 * 10;
    localparam int LIMIT    = 2 * (CONV_CYC + 650 * 10);

    logic        clk, arst_n;
    logic [11:0] awaddr, araddr;
    logic [31:0] wdata, rdata;
    logic [1:0]  bresp, rresp;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;

    integer      seed;
    int          cycles, n_checks, n_errors, chk_base, err_base;
    logic [31:0] ifm_m [256];
    logic [31:0] wt_m [9];
    logic [31:0] shadow_m [256];
    string       chk_name [$];
    logic [31:0] chk_got [$];
    logic [31:0] chk_exp [$];
    string       cur_name;
    logic [31:0] cur_got, cur_exp;

    tb_clk_gen i_clk (.clk_o(clk), .arst_n_o(arst_n));

    conv_accel_top i_dut (
        .clk_i(clk), .arst_n_i(arst_n),
        .s_awaddr_i(awaddr), .s_awvalid_i(awvalid), .s_awready_o(awready),
        .s_wdata_i(wdata), .s_wvalid_i(wvalid), .s_wready_o(wready),
        .s_bresp_o(bresp), .s_bvalid_o(bvalid), .s_bready_i(bready),
        .s_araddr_i(araddr), .s_arvalid_i(arvalid), .s_arready_o(arready),
        .s_rdata_o(rdata), .s_rresp_o(rresp), .s_rvalid_o(rvalid), .s_rready_i(rready)
    );

    function automatic logic [11:0] reg_addr(input int idx);
        return 12'(idx << 2);
    endfunction

    function automatic logic [11:0] mem_addr(input int idx);
        return 12'h400 | 12'(idx << 2);
    endfunction

    // valid 3x3 convolution wrapping at 32 bits
    function automatic logic [31:0] conv_ref(input int d, input int ox, input int oy);
        logic [31:0] acc;
        acc = '0;
        for (int ky = 0; ky < 3; ky++) begin
            for (int kx = 0; kx < 3; kx++) begin
                acc = acc + wt_m[ky * 3 + kx] * ifm_m[(oy + ky) * d + ox + kx];
            end
        end
        return acc;
    endfunction

    function automatic void expect_eq(input string name, input logic [31:0] got,
                                      input logic [31:0] exp);
        chk_name.push_back(name);
        chk_got.push_back(got);
        chk_exp.push_back(exp);
    endfunction

    always @(posedge clk) begin
        while (chk_name.size() > 0) begin
            cur_name = chk_name.pop_front();
            cur_got = chk_got.pop_front();
            cur_exp = chk_exp.pop_front();
            n_checks++;
            assert (cur_got === cur_exp) else begin
                $display("error: %s = 0x%h, expected 0x%h", cur_name, cur_got, cur_exp);
                n_errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp, input int hold);
        logic [1:0] resp;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        expect_eq("wready", 32'(wready), 32'd1);
        @(posedge clk);         // handshake edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        resp = bresp;
        repeat (hold) begin     // back-pressure on bready
            @(negedge clk);
            expect_eq("bvalid", 32'(bvalid), 32'd1);
            expect_eq("bresp", 32'(bresp), 32'(resp));
        end
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
        expect_eq("bresp", 32'(resp), 32'(exp_resp));
    endtask

    task automatic axi_read(input logic [11:0] addr, input logic [1:0] exp_resp,
                            input int hold, output logic [31:0] data);
        logic [1:0] resp;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        repeat (hold) begin
            @(negedge clk);
            expect_eq("rvalid", 32'(rvalid), 32'd1);
            expect_eq("rdata", rdata, data);
        end
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
        expect_eq("rresp", 32'(resp), 32'(exp_resp));
    endtask

    task automatic load_map(input int d);
        for (int i = 0; i < d * d; i++) begin
            ifm_m[i] = $random(seed) % 16;      // small signed values
            axi_write(mem_addr(IFM_OFF + i), ifm_m[i], RESP_OKAY, 0);
        end
        for (int t = 0; t < 9; t++) begin
            wt_m[t] = $random(seed) % 16;
            axi_write(mem_addr(WT_OFF + t), wt_m[t], RESP_OKAY, 0);
        end
    endtask

    task automatic program_dims(input int d);
        axi_write(reg_addr(REG_FM_DIM), d, RESP_OKAY, 0);
        axi_write(reg_addr(REG_IFM_OFF), IFM_OFF, RESP_OKAY, 0);
        axi_write(reg_addr(REG_WT_OFF), WT_OFF, RESP_OKAY, 0);
        axi_write(reg_addr(REG_OFM_OFF), OFM_OFF, RESP_OKAY, 0);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        st = '0;
        while (!st[0]) axi_read(reg_addr(REG_STATUS), RESP_OKAY, 0, st);
        axi_read(reg_addr(REG_STATUS), RESP_OKAY, 0, st);
        expect_eq("status", st, 32'h3);     // done and idle
    endtask

    task automatic check_outputs(input int d);
        logic [31:0] got;
        for (int oy = 0; oy < d - 2; oy++) begin
            for (int ox = 0; ox < d - 2; ox++) begin
                axi_read(mem_addr(OFM_OFF + oy * (d - 2) + ox), RESP_OKAY, 0, got);
                expect_eq($sformatf("rdata ofm[%0d]", oy * (d - 2) + ox), got,
                          conv_ref(d, ox, oy));
            end
        end
    endtask

    task automatic full_run(input int d);
        load_map(d);
        program_dims(d);
        axi_write(reg_addr(REG_CTRL), 32'h1, RESP_OKAY, 0);
        wait_done();
        check_outputs(d);
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        while (chk_name.size() != 0) @(negedge clk);
        $display("test %s: %0d checks, %0d errors", name, n_checks - chk_base,
                 n_errors - err_base);
        chk_base = n_checks;
        err_base = n_errors;
    endtask

    initial begin
        logic [31:0] got, val;
        int          idx [8];
        seed = 32'hf5be5b25;
        awaddr <= '0;
        awvalid <= 1'b0;
        wdata <= '0;
        wvalid <= 1'b0;
        bready <= 1'b0;
        araddr <= '0;
        arvalid <= 1'b0;
        rready <= 1'b0;
        cycles = 0;
        n_checks = 0;
        n_errors = 0;
        chk_base = 0;
        err_base = 0;
        wait (arst_n === 1'b1);

        axi_read(reg_addr(REG_STATUS), RESP_OKAY, 0, got);
        expect_eq("status", got, 32'h2);
        for (int r = int'(REG_FM_DIM); r <= int'(REG_OFM_OFF); r++) begin
            val = $random(seed);
            axi_write(reg_addr(r), val, RESP_OKAY, 0);
            axi_read(reg_addr(r), RESP_OKAY, 0, got);
            expect_eq("rdata", got, val);
        end
        axi_read(12'h018, RESP_SLVERR, 0, got);     // index 6 is unmapped
        axi_write(12'h01c, 32'h1234, RESP_SLVERR, 0);
        finish_test("register readback");

        for (int i = 0; i < 8; i++) begin
            idx[i] = $random(seed) & 255;
            shadow_m[idx[i]] = $random(seed);
            axi_write(mem_addr(idx[i]), shadow_m[idx[i]], RESP_OKAY, 3);
        end
        for (int i = 0; i < 8; i++) begin
            axi_read(mem_addr(idx[i]), RESP_OKAY, 3, got);
            expect_eq("rdata", got, shadow_m[idx[i]]);
        end
        finish_test("memory window");

        full_run(5);
        full_run(8);
        finish_test("convolution");

        axi_write(reg_addr(REG_CTRL), 32'h1, RESP_OKAY, 0);
        axi_read(reg_addr(REG_STATUS), RESP_OKAY, 0, got);
        expect_eq("status active", got & 32'h4, 32'h4);
        axi_write(reg_addr(REG_CTRL), 32'h1, RESP_SLVERR, 0);
        axi_read(mem_addr(IFM_OFF + 10), RESP_SLVERR, 0, got);
        expect_eq("rdata", got, 32'h0);
        axi_write(mem_addr(IFM_OFF + 10), ~ifm_m[10], RESP_SLVERR, 0);
        wait_done();
        axi_read(mem_addr(IFM_OFF + 10), RESP_OKAY, 0, got);
        expect_eq("rdata", got, ifm_m[10]);
        check_outputs(8);
        finish_test("busy rules");

        axi_write(reg_addr(REG_CTRL), 32'h2, RESP_OKAY, 0);     // clears sticky done
        axi_write(reg_addr(REG_FM_DIM), 32'd2, RESP_OKAY, 0);
        axi_write(reg_addr(REG_CTRL), 32'h1, RESP_SLVERR, 0);
        axi_write(reg_addr(REG_FM_DIM), 32'd17, RESP_OKAY, 0);
        axi_write(reg_addr(REG_CTRL), 32'h1, RESP_SLVERR, 0);
        axi_read(reg_addr(REG_STATUS), RESP_OKAY, 0, got);
        expect_eq("status", got, 32'h2);
        finish_test("invalid dimension");

        program_dims(8);
        axi_write(reg_addr(REG_CTRL), 32'h1, RESP_OKAY, 0);
        axi_read(reg_addr(REG_STATUS), RESP_OKAY, 0, got);
        expect_eq("status active", got & 32'h4, 32'h4);
        axi_write(reg_addr(REG_CTRL), 32'h2, RESP_OKAY, 0);
        axi_read(reg_addr(REG_STATUS), RESP_OKAY, 0, got);
        expect_eq("status", got, 32'h2);
        axi_read(reg_addr(REG_FM_DIM), RESP_OKAY, 0, got);
        expect_eq("rdata fm_dim", got, 32'd8);
        axi_read(reg_addr(REG_IFM_OFF), RESP_OKAY, 0, got);
        expect_eq("rdata ifm_off", got, IFM_OFF);
        axi_read(reg_addr(REG_WT_OFF), RESP_OKAY, 0, got);
        expect_eq("rdata wt_off", got, WT_OFF);
        axi_read(reg_addr(REG_OFM_OFF), RESP_OKAY, 0, got);
        expect_eq("rdata ofm_off", got, OFM_OFF);
        load_map(8);
        axi_write(reg_addr(REG_CTRL), 32'h1, RESP_OKAY, 0);
        wait_done();
        check_outputs(8);
        finish_test("soft reset");

        $display("total: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end
endmodule

/* tb.f */
src/conv_pkg.sv
src/conv_ifs.sv
src/conv_axil_slave.sv
src/conv_controller.sv
src/conv_engine.sv
src/conv_scratch_mem.sv
src/conv_accel_top.sv
bench/tb_clk_gen.sv
bench/tb_conv_accel.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_conv_accel -Mdir obj_dir
	./obj_dir/Vtb_conv_accel | tee sim.log
	@! grep -q "SIMULATION FAILED" sim.log
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
